// File: hw/ps2_defs.svh
// ps2 bus phase timing in microseconds, default clock rate and line filter length
`ifndef PS2_DEFS_SVH
`define PS2_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// clocking
////////////////////////////////////////////////////////////////////////////

// system clocks in one microsecond
`define PS2_CLK_PER_US 50
// width of the microsecond prescaler
`define PS2_TICK_W 16

////////////////////////////////////////////////////////////////////////////
// host to device phases, all in microseconds
////////////////////////////////////////////////////////////////////////////

// clock held low to inhibit the device
`define PS2_INHIBIT_US 120
// data pulled low this far into the inhibit
`define PS2_RTS_US 60
// clock release to end of transfer
`define PS2_TIMEOUT_US 2000

// equal samples needed before a line level is taken
`define PS2_FILTER_LEN 4

`endif

// File: hw/ps2_pkg.sv
// byte, frame and status types and the transmitter state enum
`default_nettype none

package ps2_pkg;

	// one command byte from the client
	typedef logic [7:0] ps2_byte_t;

	// bit 0 goes out first
	// start, data lsb first, odd parity, stop
	typedef logic [10:0] ps2_frame_t;

	// completion code back to the client
	typedef enum logic [1:0] {
		ST_OK      = 2'd0,
		ST_NACK    = 2'd1,
		ST_TIMEOUT = 2'd2
	} ps2_status_t;

	// host transmitter phases
	typedef enum logic [2:0] {
		TX_IDLE      = 3'd0,
		TX_INHIBIT   = 3'd1,
		TX_WAIT_FALL = 3'd2,
		TX_SEND      = 3'd3,
		TX_WAIT_ACK  = 3'd4,
		TX_WAIT_IDLE = 3'd5,
		TX_DONE      = 3'd6
	} tx_state_t;

endpackage

`default_nettype wire

// File: hw/ps2_if.sv
// interfaces ps2_line_if and ps2_frame_if with their modports
`timescale 1ns/1ps
`default_nettype none

// conditioned bus lines and device clock edges
interface ps2_line_if;
	logic clk_level;
	logic data_level;
	// single cycle pulses
	logic clk_fall;
	logic clk_rise;

	modport src (output clk_level, data_level, clk_fall, clk_rise);
	modport dst (input clk_level, data_level, clk_fall, clk_rise);
endinterface

// framer to transmitter, four phase req/ack
interface ps2_frame_if
	import ps2_pkg::*;
();
	ps2_frame_t  frame;
	logic        req;
	logic        ack;
	// valid while ack is high
	ps2_status_t status;

	modport ctl (output frame, req, input ack, status);
	modport bus (input frame, req, output ack, status);
endinterface

`default_nettype wire

// File: hw/ps2_line_sync.sv
// two flop synchroniser, run length deglitch filter and clock edge detect
`timescale 1ns/1ps
`default_nettype none
`include "ps2_defs.svh"

module ps2_line_sync (
	input  logic    qzt_clk,
	input  logic    reset,
	input  logic    ps2c_in,
	input  logic    ps2d_in,
	ps2_line_if.src line
);

	localparam int FLT_W = $clog2(`PS2_FILTER_LEN + 1);
	localparam logic [FLT_W-1:0] FLT_LAST = FLT_W'(`PS2_FILTER_LEN - 1);

	// bit 0 is the clock line, bit 1 the data line
	logic [1:0]       meta_q;
	logic [1:0]       sync_q;
	logic [1:0]       level_q;
	logic [FLT_W-1:0] run_q [2];
	logic             clk_prev_q;

	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			// idle bus is pulled high
			meta_q     <= 2'b11;
			sync_q     <= 2'b11;
			level_q    <= 2'b11;
			clk_prev_q <= 1'b1;
			for (int i = 0; i < 2; i++) begin
				run_q[i] <= '0;
			end
		end else begin
			meta_q     <= {ps2d_in, ps2c_in};
			sync_q     <= meta_q;
			clk_prev_q <= level_q[0];
			for (int i = 0; i < 2; i++) begin
				// any sample back at the old level restarts the run
				if (sync_q[i] == level_q[i]) begin
					run_q[i] <= '0;
				end else if (run_q[i] == FLT_LAST) begin
					level_q[i] <= sync_q[i];
					run_q[i]   <= '0;
				end else begin
					run_q[i] <= run_q[i] + 1'b1;
				end
			end
		end
	end

	assign line.clk_level  = level_q[0];
	assign line.data_level = level_q[1];
	// edge pulses line up with the new level
	assign line.clk_fall   = clk_prev_q & ~level_q[0];
	assign line.clk_rise   = ~clk_prev_q & level_q[0];

	a_one_edge: assert property (@(posedge qzt_clk) disable iff (reset)
		!(line.clk_fall && line.clk_rise));

endmodule

`default_nettype wire

// File: hw/ps2_cmd_framer.sv
// client handshake, odd parity, frame assembly and status return
`timescale 1ns/1ps
`default_nettype none

module ps2_cmd_framer
	import ps2_pkg::*;
(
	input  logic        qzt_clk,
	input  logic        reset,
	input  logic        cmd_req,
	input  ps2_byte_t   cmd_data,
	output logic        cmd_ack,
	output ps2_status_t cmd_status,
	ps2_frame_if.ctl    frame
);

	ps2_byte_t byte_q;
	logic      req_q;
	logic      accept;
	logic      finish;

	// new command only once both handshakes are back at zero
	assign accept = cmd_req && !cmd_ack && !req_q && !frame.ack;
	// transmitter is through with the frame
	assign finish = req_q && frame.ack;

	always_ff @(posedge qzt_clk) begin
		if (accept) begin
			byte_q <= cmd_data;
		end
	end

	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			req_q   <= 1'b0;
			cmd_ack <= 1'b0;
		end else if (accept) begin
			req_q <= 1'b1;
		end else if (finish) begin
			req_q   <= 1'b0;
			cmd_ack <= 1'b1;
		end else if (cmd_ack && !cmd_req) begin
			cmd_ack <= 1'b0;
		end
	end

	// held for the client until the next finish
	always_ff @(posedge qzt_clk) begin
		if (finish) begin
			cmd_status <= frame.status;
		end
	end

	assign frame.req = req_q;
	// stop, parity, data, start from msb down
	assign frame.frame = {1'b1, ~^byte_q, byte_q, 1'b0};

	a_req_after_ack: assert property (@(posedge qzt_clk) disable iff (reset)
		$rose(frame.req) |-> !frame.ack);

	a_ack_holds: assert property (@(posedge qzt_clk) disable iff (reset)
		$fell(cmd_ack) |-> !$past(cmd_req));

endmodule

`default_nettype wire

// File: hw/ps2_host_tx.sv
// host to device transmit FSM with inhibit, request-to-send, shifting, ack and timeout
`timescale 1ns/1ps
`default_nettype none
`include "ps2_defs.svh"

module ps2_host_tx
	import ps2_pkg::*;
#(
	parameter int CLK_PER_US = `PS2_CLK_PER_US
) (
	input  logic     qzt_clk,
	input  logic     reset,
	ps2_line_if.dst  line,
	ps2_frame_if.bus frame,
	output logic     ps2c_drive_low,
	output logic     ps2d_drive_low
);

	////////////////////////////////////////////////////////////////////////////
	// constants
	////////////////////////////////////////////////////////////////////////////

	localparam int TMR_W = $clog2(`PS2_TIMEOUT_US + 1);

	localparam logic [`PS2_TICK_W-1:0] TICK_LAST = `PS2_TICK_W'(CLK_PER_US - 1);
	// per phase loads of the down-counter
	localparam logic [TMR_W-1:0] LOAD_RTS     = TMR_W'(`PS2_RTS_US);
	localparam logic [TMR_W-1:0] LOAD_HOLD    = TMR_W'(`PS2_INHIBIT_US - `PS2_RTS_US);
	localparam logic [TMR_W-1:0] LOAD_TIMEOUT = TMR_W'(`PS2_TIMEOUT_US);
	// stop bit is the last one we drive
	localparam logic [3:0] LAST_BIT = 4'd10;

	tx_state_t              state_q;
	logic [`PS2_TICK_W-1:0] presc_q;
	logic [TMR_W-1:0]       timer_q;
	logic [3:0]             bit_idx_q;
	ps2_frame_t             shift_q;
	logic                   clk_low_q;
	logic                   data_low_q;
	logic                   ack_q;

	logic tick;
	logic expired;
	logic in_transfer;
	logic timed_out;
	logic ack_sample;

	////////////////////////////////////////////////////////////////////////////
	// microsecond tick and phase timer
	////////////////////////////////////////////////////////////////////////////

	assign tick    = (presc_q == TICK_LAST);
	// last microsecond of the loaded phase
	assign expired = tick && (timer_q == TMR_W'(1));

	// held at zero in idle so the inhibit starts on a clean microsecond
	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			presc_q <= '0;
		end else if (state_q == TX_IDLE || tick) begin
			presc_q <= '0;
		end else begin
			presc_q <= presc_q + 1'b1;
		end
	end

	// device owns the clock from release until done
	assign in_transfer = (state_q == TX_WAIT_FALL) || (state_q == TX_SEND) ||
		(state_q == TX_WAIT_ACK) || (state_q == TX_WAIT_IDLE);
	assign timed_out   = in_transfer && expired;
	// device pulls data low for ack, then falls the clock
	assign ack_sample  = (state_q == TX_WAIT_ACK) && line.clk_fall;

	////////////////////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge qzt_clk) begin
		if (reset) begin
			state_q    <= TX_IDLE;
			timer_q    <= '0;
			bit_idx_q  <= '0;
			clk_low_q  <= 1'b0;
			data_low_q <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			if (tick && timer_q != '0) begin
				timer_q <= timer_q - 1'b1;
			end
			if (timed_out) begin
				// let go of both lines, the device is gone
				clk_low_q  <= 1'b0;
				data_low_q <= 1'b0;
				ack_q      <= 1'b1;
				state_q    <= TX_DONE;
			end else begin
				case (state_q)
					TX_IDLE: begin
						if (frame.req) begin
							clk_low_q <= 1'b1;
							timer_q   <= LOAD_RTS;
							bit_idx_q <= 4'd1;
							state_q   <= TX_INHIBIT;
						end
					end
					// first expiry is rts, second ends the inhibit
					TX_INHIBIT: begin
						if (expired) begin
							if (!data_low_q) begin
								data_low_q <= 1'b1;
								timer_q    <= LOAD_HOLD;
							end else begin
								clk_low_q <= 1'b0;
								timer_q   <= LOAD_TIMEOUT;
								state_q   <= TX_WAIT_FALL;
							end
						end
					end
					TX_WAIT_FALL: begin
						if (line.clk_fall) begin
							state_q <= TX_SEND;
						end
					end
					// next bit onto the line, device reads it on the rise
					TX_SEND: begin
						data_low_q <= ~shift_q[1];
						if (bit_idx_q == LAST_BIT) begin
							state_q <= TX_WAIT_ACK;
						end else begin
							bit_idx_q <= bit_idx_q + 1'b1;
							state_q   <= TX_WAIT_FALL;
						end
					end
					TX_WAIT_ACK: begin
						if (line.clk_fall) begin
							state_q <= TX_WAIT_IDLE;
						end
					end
					// both lines high again before reporting
					TX_WAIT_IDLE: begin
						if (line.clk_level && line.data_level) begin
							ack_q   <= 1'b1;
							state_q <= TX_DONE;
						end
					end
					TX_DONE: begin
						if (!frame.req) begin
							ack_q   <= 1'b0;
							state_q <= TX_IDLE;
						end
					end
					default: begin
						state_q <= TX_IDLE;
					end
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// frame shifter and status
	////////////////////////////////////////////////////////////////////////////

	// start bit is never shifted out, rts already drove it
	always_ff @(posedge qzt_clk) begin
		if (state_q == TX_IDLE && frame.req) begin
			shift_q <= frame.frame;
		end else if (state_q == TX_SEND) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_ff @(posedge qzt_clk) begin
		if (timed_out) begin
			frame.status <= ST_TIMEOUT;
		end else if (ack_sample) begin
			if (line.data_level) begin
				frame.status <= ST_NACK;
			end else begin
				frame.status <= ST_OK;
			end
		end
	end

	assign frame.ack      = ack_q;
	assign ps2c_drive_low = clk_low_q;
	assign ps2d_drive_low = data_low_q;

	a_idle_released: assert property (@(posedge qzt_clk) disable iff (reset)
		(state_q == TX_IDLE) |-> (!ps2c_drive_low && !ps2d_drive_low));

	a_ack_in_req: assert property (@(posedge qzt_clk) disable iff (reset)
		$rose(frame.ack) |-> frame.req);

endmodule

`default_nettype wire

// File: hw/ps2_host.sv
// top level joining line sync, command framer and host transmitter
`timescale 1ns/1ps
`default_nettype none
`include "ps2_defs.svh"

module ps2_host
	import ps2_pkg::*;
#(
	parameter int CLK_PER_US = `PS2_CLK_PER_US
) (
	input  logic        qzt_clk,
	input  logic        reset,
	// client side, four phase
	input  logic        cmd_req,
	input  ps2_byte_t   cmd_data,
	output logic        cmd_ack,
	output ps2_status_t cmd_status,
	// open drain bus split into sense and pull-down
	input  logic        ps2c_in,
	input  logic        ps2d_in,
	output logic        ps2c_drive_low,
	output logic        ps2d_drive_low
);

	ps2_line_if  u_line_if ();
	ps2_frame_if u_frame_if ();

	// stage 1, raw pins to clean levels and edges
	ps2_line_sync u_sync (
		.qzt_clk (qzt_clk),
		.reset   (reset),
		.ps2c_in (ps2c_in),
		.ps2d_in (ps2d_in),
		.line    (u_line_if.src)
	);

	// stage 2, byte to frame
	ps2_cmd_framer u_framer (
		.qzt_clk    (qzt_clk),
		.reset      (reset),
		.cmd_req    (cmd_req),
		.cmd_data   (cmd_data),
		.cmd_ack    (cmd_ack),
		.cmd_status (cmd_status),
		.frame      (u_frame_if.ctl)
	);

	// stage 3, frame onto the bus
	ps2_host_tx #(
		.CLK_PER_US (CLK_PER_US)
	) u_tx (
		.qzt_clk        (qzt_clk),
		.reset          (reset),
		.line           (u_line_if.dst),
		.frame          (u_frame_if.bus),
		.ps2c_drive_low (ps2c_drive_low),
		.ps2d_drive_low (ps2d_drive_low)
	);

endmodule

`default_nettype wire

// File: sim/ps2_device_model.sv
// behavioural ps2 device that clocks in a host frame and answers with ack, nack or silence
`timescale 1ns/1ps
`default_nettype none

module ps2_device_model
	import ps2_pkg::*;
#(
	parameter int HALF_CYC = 80
) (
	input  logic       qzt_clk,
	input  logic       reset,
	// resolved bus levels
	input  logic       ps2c,
	input  logic       ps2d,
	// 0 ack, 1 nack, 2 mute
	input  logic [1:0] mode,
	output logic       clk_drive_low,
	output logic       data_drive_low,
	output ps2_frame_t rx_frame,
	output logic       done
);

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge qzt_clk);
	endtask

	// bits 1 to 10 on ten device clocks, then the ack clock
	task automatic clock_in_frame();
		ps2_frame_t f;
		f = '0;
		// start bit is the rts data low
		f[0] = ps2d;
		wait_cycles(HALF_CYC);
		for (int i = 1; i < 11; i++) begin
			clk_drive_low = 1'b1;
			wait_cycles(HALF_CYC);
			// host changed data while the clock was low, read it on the rise
			f[i] = ps2d;
			clk_drive_low = 1'b0;
			wait_cycles(HALF_CYC);
		end
		// ack is data low ahead of the last fall
		if (mode == 2'd0) begin
			data_drive_low = 1'b1;
		end
		wait_cycles(HALF_CYC / 2);
		clk_drive_low = 1'b1;
		wait_cycles(HALF_CYC);
		clk_drive_low  = 1'b0;
		data_drive_low = 1'b0;
		rx_frame       = f;
		done           = 1'b1;
		wait_cycles(1);
		done = 1'b0;
	endtask

	initial begin
		clk_drive_low  = 1'b0;
		data_drive_low = 1'b0;
		rx_frame       = '0;
		done           = 1'b0;
		@(negedge qzt_clk);
		while (reset) begin
			@(negedge qzt_clk);
		end
		forever begin
			// inhibit plus rts, both lines low
			while (ps2c || ps2d) begin
				@(negedge qzt_clk);
			end
			// host lets go of the clock, data stays low
			while (!ps2c) begin
				@(negedge qzt_clk);
			end
			if (mode == 2'd2) begin
				// mute, wait for the host to give up and release data
				while (!ps2d) begin
					@(negedge qzt_clk);
				end
			end else begin
				clock_in_frame();
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_ps2_host.sv
// testbench for the ps2 host with clock, reset, lfsr stimulus, reference model, checks, watchdog
`timescale 1ns/1ps
`default_nettype none
`include "ps2_defs.svh"

module tb_ps2_host
	import ps2_pkg::*;
();

	localparam int CLK_PER_US   = 2;
	localparam int NUM_CMDS     = 40;
	localparam int INHIBIT_CYC  = `PS2_INHIBIT_US * CLK_PER_US;
	localparam int RTS_CYC      = `PS2_RTS_US * CLK_PER_US;
	// full timeout plus margin
	localparam int ACK_WAIT_CYC = (`PS2_INHIBIT_US + `PS2_TIMEOUT_US + 200) * CLK_PER_US;
	// 10 ns per cycle
	localparam int WATCHDOG_NS  = NUM_CMDS * (`PS2_TIMEOUT_US + 200) * CLK_PER_US * 10;
	localparam logic [1:0] MODE_ACK  = 2'd0;
	localparam logic [1:0] MODE_NACK = 2'd1;
	localparam logic [1:0] MODE_MUTE = 2'd2;

	logic        qzt_clk;
	logic        reset;
	logic        cmd_req;
	ps2_byte_t   cmd_data;
	logic        cmd_ack;
	ps2_status_t cmd_status;
	logic        ps2c_in;
	logic        ps2d_in;
	logic        ps2c_drive_low;
	logic        ps2d_drive_low;
	logic        dev_clk_low;
	logic        dev_data_low;
	logic [1:0]  dev_mode;
	ps2_frame_t  dev_frame;
	logic        dev_done;
	int          done_count;
	logic [31:0] lfsr_q;

	////////////////////////////////////////////////////////////////////////////
	// DUT, device and wired-AND bus
	////////////////////////////////////////////////////////////////////////////

	ps2_host #(.CLK_PER_US(CLK_PER_US)) u_dut (
		.qzt_clk(qzt_clk), .reset(reset), .cmd_req(cmd_req), .cmd_data(cmd_data),
		.cmd_ack(cmd_ack), .cmd_status(cmd_status), .ps2c_in(ps2c_in), .ps2d_in(ps2d_in),
		.ps2c_drive_low(ps2c_drive_low), .ps2d_drive_low(ps2d_drive_low)
	);

	ps2_device_model #(.HALF_CYC(40 * CLK_PER_US)) u_device (
		.qzt_clk(qzt_clk), .reset(reset), .ps2c(ps2c_in), .ps2d(ps2d_in), .mode(dev_mode),
		.clk_drive_low(dev_clk_low), .data_drive_low(dev_data_low),
		.rx_frame(dev_frame), .done(dev_done)
	);

	// x before reset reads as released
	assign ps2c_in = !((ps2c_drive_low === 1'b1) || dev_clk_low);
	assign ps2d_in = !((ps2d_drive_low === 1'b1) || dev_data_low);

	initial qzt_clk = 1'b0;
	always #5 qzt_clk = ~qzt_clk;

	// frames the device finished
	always @(posedge qzt_clk) begin
		if (reset) begin
			done_count <= 0;
		end else if (dev_done) begin
			done_count <= done_count + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus source and reference model
	////////////////////////////////////////////////////////////////////////////

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// start, data lsb first, odd parity, stop
	function automatic ps2_frame_t expected_frame(input ps2_byte_t b);
		ps2_frame_t f;
		int         ones;
		ones = 0;
		f[0] = 1'b0;
		for (int i = 0; i < 8; i++) begin
			f[i + 1] = b[i];
			ones += int'(b[i]);
		end
		f[9]  = (ones % 2 == 0);
		f[10] = 1'b1;
		return f;
	endfunction

	function automatic ps2_status_t expected_status(input logic [1:0] mode);
		ps2_status_t s;
		case (mode)
			MODE_ACK:  s = ST_OK;
			MODE_NACK: s = ST_NACK;
			default:   s = ST_TIMEOUT;
		endcase
		return s;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Test failed");
		$fatal(1, "%s", what);
	endtask

	task automatic check_frame(input string name, input ps2_frame_t got, input ps2_frame_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
			stop_on_error("frame mismatch");
		end
	endtask

	task automatic check_status(input string name, input ps2_status_t got,
		input ps2_status_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %s expected %s", $time, name,
				got.name(), exp.name());
			stop_on_error("status mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
			stop_on_error("control signal mismatch");
		end
	endtask

	// one microsecond tick either way
	task automatic check_cycles(input string name, input int got, input int exp);
		if (got < exp - CLK_PER_US || got > exp + CLK_PER_US) begin
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			stop_on_error("phase length out of range");
		end
	endtask

	task automatic expect_released();
		check_bit("ps2c_drive_low", ps2c_drive_low, 1'b0);
		check_bit("ps2d_drive_low", ps2d_drive_low, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per command sequence
	////////////////////////////////////////////////////////////////////////////

	task automatic measure_inhibit();
		int cnt;
		int rts_at;
		cnt = 0;
		rts_at = -1;
		// framer takes a cycle, transmitter one more
		while (!ps2c_drive_low) begin
			@(negedge qzt_clk);
			cnt++;
			if (cnt > 4) begin
				stop_on_error("ps2c_drive_low did not assert after cmd_req");
			end
		end
		cnt = 0;
		while (ps2c_drive_low) begin
			@(negedge qzt_clk);
			cnt++;
			if (ps2d_drive_low && rts_at < 0) begin
				rts_at = cnt;
			end
			if (cnt > 2 * INHIBIT_CYC) begin
				stop_on_error("clock inhibit never ended");
			end
		end
		check_cycles("ps2c_drive_low high time", cnt, INHIBIT_CYC);
		check_cycles("ps2d_drive_low delay", rts_at, RTS_CYC);
		check_bit("rts before clock release", rts_at > 0 && rts_at < cnt, 1'b1);
	endtask

	task automatic wait_for_ack();
		int cnt;
		cnt = 0;
		while (!cmd_ack) begin
			@(negedge qzt_clk);
			cnt++;
			if (cnt > ACK_WAIT_CYC) begin
				stop_on_error("DUT never raised cmd_ack");
			end
		end
	endtask

	task automatic run_command();
		logic [31:0] r;
		ps2_byte_t   b;
		logic [1:0]  mode;
		int          pre;
		int          hold;
		int          done_before;
		rand_bits(8, r);
		b = r[7:0];
		// six in eight ack, one nack, one mute
		rand_bits(3, r);
		case (r[2:0])
			3'd6:    mode = MODE_NACK;
			3'd7:    mode = MODE_MUTE;
			default: mode = MODE_ACK;
		endcase
		rand_bits(4, r);
		pre = int'(r[3:0]);
		rand_bits(4, r);
		hold = int'(r[3:0]);
		dev_mode = mode;
		cmd_data = b;
		// quiet bus while the client is idle
		repeat (pre) begin
			@(negedge qzt_clk);
			check_bit("cmd_ack", cmd_ack, 1'b0);
			expect_released();
		end
		done_before = done_count;
		cmd_req = 1'b1;
		measure_inhibit();
		wait_for_ack();
		expect_released();
		check_status("cmd_status", cmd_status, expected_status(mode));
		if (mode == MODE_MUTE) begin
			check_bit("device frame done", done_count == done_before, 1'b1);
		end else begin
			check_bit("device frame done", done_count == done_before + 1, 1'b1);
			check_frame("device rx_frame", dev_frame, expected_frame(b));
		end
		// slow client, ack holds and the bus stays free
		repeat (hold) begin
			@(negedge qzt_clk);
			check_bit("cmd_ack", cmd_ack, 1'b1);
			expect_released();
		end
		cmd_req = 1'b0;
		@(negedge qzt_clk);
		check_bit("cmd_ack after cmd_req fell", cmd_ack, 1'b0);
	endtask

	initial begin
		reset    = 1'b1;
		cmd_req  = 1'b0;
		cmd_data = '0;
		dev_mode = MODE_ACK;
		lfsr_q   = 32'h9042_d535;
		repeat (10) begin
			@(negedge qzt_clk);
			check_bit("cmd_ack", cmd_ack, 1'b0);
			expect_released();
		end
		reset = 1'b0;
		for (int n = 0; n < NUM_CMDS; n++) begin
			run_command();
		end
		$display("Test passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_on_error("watchdog expired before all commands finished");
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/ps2_pkg.sv
hw/ps2_if.sv
hw/ps2_line_sync.sv
hw/ps2_cmd_framer.sv
hw/ps2_host_tx.sv
hw/ps2_host.sv
sim/ps2_device_model.sv
sim/tb_ps2_host.sv

// File: run_sim.sh
#!/bin/sh
# build the ps2 host testbench with verilator and run it
# exit status is the simulator's, nonzero on $fatal
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module tb_ps2_host \
	-f files.f \
	-o tb_ps2_host
./obj_dir/tb_ps2_host
